// File: common/tlul_pkg.sv
// ============================================================
// TL-UL bus widths and channel encodings
// Opcode, fetch enable and request type enums
// ============================================================
package tlul_pkg;

  // Bus data width and bytes per bus word
  parameter int TlDw  = 32;
  parameter int TlDbw = TlDw / 8;

  // Address, size and source field widths
  parameter int TlAw  = 32;
  parameter int TlSzw = 2;
  parameter int TlAiw = 8;

  // A channel opcodes as defined by the TL-UL spec
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Instruction fetch permission
  typedef enum logic {
    InstrDis = 1'b0,
    InstrEn  = 1'b1
  } tl_instr_en_e;

  // Request type carried in the A channel user bits
  typedef enum logic {
    DataType  = 1'b0,
    InstrType = 1'b1
  } tl_type_e;

endpackage

// File: common/sram_adapter_pkg.sv
// ============================================================
// Adapter internal types: recorded operation and the
// pending request and read lane FIFO entries
// ============================================================
package sram_adapter_pkg;

  // Operation as recorded for a pending request
  typedef enum logic {
    OpWrite = 1'b0,
    OpRead  = 1'b1
  } req_op_e;

  // One accepted bus request waiting for its D beat
  typedef struct packed {
    req_op_e                      op;
    logic                         error;
    logic [tlul_pkg::TlSzw-1:0]   size;
    logic [tlul_pkg::TlAiw-1:0]   source;
  } pend_req_t;

  // Byte lanes of a granted read and its bus word inside the SRAM word
  // The 2 bit offset limits the SRAM word to 4 bus words
  typedef struct packed {
    logic [tlul_pkg::TlDbw-1:0] mask;
    logic [1:0]                 woffset;
  } lane_req_t;

endpackage

// File: common/adapter_ifs.sv
// ============================================================
// Stage interfaces: decode to issue, and the pending FIFO
// heads from issue to the response builder
// ============================================================
`timescale 1ns/1ps

interface req_dec_if #(
  parameter int SramAw = 12
);

  logic                             valid;
  sram_adapter_pkg::req_op_e        op;
  logic                             error;
  logic [tlul_pkg::TlSzw-1:0]       size;
  logic [tlul_pkg::TlAiw-1:0]       source;
  logic [SramAw-1:0]                addr;
  // Bus word position inside the SRAM word
  logic [1:0]                       woffset;
  logic [tlul_pkg::TlDbw-1:0]       mask;
  logic [tlul_pkg::TlDw-1:0]        wdata;
  logic                             we;

  modport dec (output valid, op, error, size, source, addr, woffset, mask, wdata, we);
  modport iss (input  valid, op, error, size, source, addr, woffset, mask, wdata, we);

endinterface

interface pend_if;

  // Head of the request FIFO
  logic                          req_valid;
  sram_adapter_pkg::pend_req_t   req;
  // Head of the read lane FIFO
  sram_adapter_pkg::lane_req_t   lane;
  // Pops come back from the response builder
  logic                          req_pop;
  logic                          lane_pop;

  modport iss (output req_valid, req, lane, input  req_pop, lane_pop);
  modport rsp (input  req_valid, req, lane, output req_pop, lane_pop);

endinterface

// File: logic/sync_fifo.sv
// ============================================================
// Synchronous circular buffer FIFO with optional
// pass-through of a word written while empty
// ============================================================
`timescale 1ns/1ps

module sync_fifo #(
  parameter int Width = 8,
  parameter int Depth = 2,
  parameter bit Pass  = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [Width-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wptr_q, rptr_q;
  logic [CntW-1:0]  cnt_q;
  logic             empty, full, bypass, push, pop;

  assign empty = (cnt_q == '0);
  assign full  = (cnt_q == CntW'(Depth));

  // A word is bypassed when it arrives at an empty FIFO and leaves at once
  assign bypass = Pass && empty && wvalid_i && rready_i;
  assign push   = wvalid_i && !full && !bypass;
  assign pop    = rready_i && !empty;

  assign wready_o = !full;
  assign rvalid_o = !empty || (Pass && wvalid_i);
  assign rdata_o  = (Pass && empty) ? wdata_i : mem_q[rptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      // Count only changes when push and pop do not cancel
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

// File: sram_adapter/tlul_req_decode.sv
// ============================================================
// A channel decode: op, SRAM word address and offset,
// and detection of every request error
// ============================================================
`timescale 1ns/1ps

module tlul_req_decode #(
  parameter int SramAw     = 12,
  parameter int SramDw     = 32,
  parameter bit ByteAccess = 1'b1,
  parameter bit ErrOnWrite = 1'b0,
  parameter bit ErrOnRead  = 1'b0
) (
  input  logic                         a_valid_i,
  input  tlul_pkg::tl_a_op_e           a_opcode_i,
  input  logic [tlul_pkg::TlSzw-1:0]   a_size_i,
  input  logic [tlul_pkg::TlAiw-1:0]   a_source_i,
  input  logic [tlul_pkg::TlAw-1:0]    a_address_i,
  input  logic [tlul_pkg::TlDbw-1:0]   a_mask_i,
  input  logic [tlul_pkg::TlDw-1:0]    a_data_i,
  input  tlul_pkg::tl_type_e           a_type_i,
  input  tlul_pkg::tl_instr_en_e       en_ifetch_i,
  req_dec_if.dec                       dec_if
);

  // Byte address bits below the SRAM word
  localparam int SramByteBits = $clog2(SramDw / 8);
  localparam logic [1:0] WoffMask = 2'(SramDw / tlul_pkg::TlDw - 1);

  logic                       is_get, is_put_full, is_put_part, is_write;
  logic [tlul_pkg::TlDbw-1:0] lane_mask;
  logic op_err, size_err, align_err, mask_err, full_err;
  logic byte_err, mode_err, instr_err;

  assign is_get      = (a_opcode_i == tlul_pkg::Get);
  assign is_put_full = (a_opcode_i == tlul_pkg::PutFullData);
  assign is_put_part = (a_opcode_i == tlul_pkg::PutPartialData);
  assign is_write    = is_put_full || is_put_part;

  // Byte lanes covered by the addressed size
  always_comb begin
    case (a_size_i)
      2'd0:    lane_mask = 4'b0001 << a_address_i[1:0];
      2'd1:    lane_mask = 4'b0011 << {a_address_i[1], 1'b0};
      2'd2:    lane_mask = 4'b1111;
      default: lane_mask = 4'b0000;
    endcase
  end

  // Basic protocol checks
  assign op_err    = !(is_get || is_write);
  assign size_err  = (a_size_i > 2'd2);
  assign align_err = ((a_size_i == 2'd1) && a_address_i[0]) ||
                     ((a_size_i == 2'd2) && (a_address_i[1:0] != 2'b00));
  assign mask_err  = |(a_mask_i & ~lane_mask);
  // A full put must write every addressed byte
  assign full_err  = is_put_full && (a_mask_i != lane_mask);

  // Without byte access only whole bus words may be written
  assign byte_err  = !ByteAccess && is_write &&
                     ((a_mask_i != '1) || (a_size_i != 2'd2));
  assign mode_err  = (ErrOnWrite && !is_get) || (ErrOnRead && is_get);
  assign instr_err = (a_type_i == tlul_pkg::InstrType) && (en_ifetch_i != tlul_pkg::InstrEn);

  assign dec_if.valid  = a_valid_i;
  // Unknown opcodes are recorded as writes so they answer with AccessAck
  assign dec_if.op     = is_get ? sram_adapter_pkg::OpRead : sram_adapter_pkg::OpWrite;
  assign dec_if.error  = op_err || size_err || align_err || mask_err || full_err ||
                         byte_err || mode_err || instr_err;
  assign dec_if.size   = a_size_i;
  assign dec_if.source = a_source_i;
  assign dec_if.addr   = a_address_i[SramByteBits +: SramAw];
  assign dec_if.woffset = a_address_i[3:2] & WoffMask;
  assign dec_if.mask   = a_mask_i;
  assign dec_if.wdata  = a_data_i;
  assign dec_if.we     = is_write;

endmodule

// File: sram_adapter/sram_req_issue.sv
// ============================================================
// SRAM request issue with write lane placement, and the
// request and read lane pending FIFOs
// ============================================================
`timescale 1ns/1ps

module sram_req_issue #(
  parameter int SramAw      = 12,
  parameter int SramDw      = 32,
  parameter int Outstanding = 2
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  req_dec_if.iss            iss_if,
  input  logic              gnt_i,
  output logic              a_ready_o,
  output logic              req_o,
  output logic              we_o,
  output logic [SramAw-1:0] addr_o,
  output logic [SramDw-1:0] wdata_o,
  output logic [SramDw-1:0] wmask_o,
  pend_if.iss               pend_o
);

  localparam int WidthMult = SramDw / tlul_pkg::TlDw;
  localparam int ReqW      = $bits(sram_adapter_pkg::pend_req_t);
  localparam int LaneW     = $bits(sram_adapter_pkg::lane_req_t);

  logic                        req_wready, lane_wready;
  logic                        a_ack, rd_ack;
  sram_adapter_pkg::pend_req_t req_entry;
  sram_adapter_pkg::lane_req_t lane_entry;

  // The SRAM grant also gates acceptance of errored requests
  assign a_ready_o = gnt_i && req_wready && lane_wready;
  assign a_ack     = iss_if.valid && a_ready_o;

  // Errored requests are squashed before the SRAM
  assign req_o  = iss_if.valid && req_wready && !iss_if.error;
  assign we_o   = iss_if.valid && iss_if.we;
  assign addr_o = iss_if.addr;
  assign rd_ack = req_o && gnt_i && !we_o;

  // Place the bus word in its lane; unmasked bytes are written as zero
  always_comb begin
    wmask_o = '0;
    wdata_o = '0;
    for (int w = 0; w < WidthMult; w++) begin
      if (w == int'(iss_if.woffset)) begin
        for (int i = 0; i < tlul_pkg::TlDbw; i++) begin
          wmask_o[w*tlul_pkg::TlDw + 8*i +: 8] = {8{iss_if.mask[i]}};
          if (iss_if.mask[i] && iss_if.we) begin
            wdata_o[w*tlul_pkg::TlDw + 8*i +: 8] = iss_if.wdata[8*i +: 8];
          end
        end
      end
    end
  end

  assign req_entry  = '{op: iss_if.op, error: iss_if.error,
                        size: iss_if.size, source: iss_if.source};
  assign lane_entry = '{mask: iss_if.mask, woffset: iss_if.woffset};

  // Every accepted request waits here until its D beat
  sync_fifo #(.Width(ReqW), .Depth(Outstanding), .Pass(1'b0)) u_req_fifo (
    .clk_i,
    .rst_ni,
    .wvalid_i(a_ack),
    .wready_o(req_wready),
    .wdata_i (req_entry),
    .rvalid_o(pend_o.req_valid),
    .rready_i(pend_o.req_pop),
    .rdata_o (pend_o.req)
  );

  // Lane of each granted read, held until the data returns
  sync_fifo #(.Width(LaneW), .Depth(Outstanding), .Pass(1'b0)) u_lane_fifo (
    .clk_i,
    .rst_ni,
    .wvalid_i(rd_ack),
    .wready_o(lane_wready),
    .wdata_i (lane_entry),
    .rvalid_o(),
    .rready_i(pend_o.lane_pop),
    .rdata_o (pend_o.lane)
  );

endmodule

// File: sram_adapter/tlul_rsp_build.sv
// ============================================================
// Read lane extraction, pass-through response FIFO and
// D channel beat assembly
// ============================================================
`timescale 1ns/1ps

module tlul_rsp_build #(
  parameter int SramDw      = 32,
  parameter int Outstanding = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  pend_if.rsp                          pend_i,
  input  logic [SramDw-1:0]            rdata_i,
  input  logic                         rvalid_i,
  input  logic                         rerror_i,
  input  logic                         d_ready_i,
  output logic                         d_valid_o,
  output tlul_pkg::tl_d_op_e           d_opcode_o,
  output logic [tlul_pkg::TlSzw-1:0]   d_size_o,
  output logic [tlul_pkg::TlAiw-1:0]   d_source_o,
  output logic [tlul_pkg::TlDw-1:0]    d_data_o,
  output logic                         d_error_o
);

  localparam int WidthMult = SramDw / tlul_pkg::TlDw;

  logic [tlul_pkg::TlDw-1:0] lane_data;
  logic [tlul_pkg::TlDw:0]   rsp_wdata, rsp_rdata;
  logic                      rsp_wvalid, rsp_rvalid, rsp_pop;
  logic                      is_read, good_read, d_ack;

  // Pick the bus word and keep only the requested bytes
  always_comb begin
    lane_data = '0;
    for (int w = 0; w < WidthMult; w++) begin
      if (w == int'(pend_i.lane.woffset)) begin
        lane_data = rdata_i[w*tlul_pkg::TlDw +: tlul_pkg::TlDw];
      end
    end
    for (int i = 0; i < tlul_pkg::TlDbw; i++) begin
      if (!pend_i.lane.mask[i]) begin
        lane_data[8*i +: 8] = 8'h00;
      end
    end
  end

  // Read data cannot be stalled, so it always lands here
  assign rsp_wvalid      = rvalid_i && pend_i.req_valid;
  assign rsp_wdata       = {rerror_i, lane_data};
  assign pend_i.lane_pop = rsp_wvalid;

  sync_fifo #(.Width(tlul_pkg::TlDw + 1), .Depth(Outstanding), .Pass(1'b1)) u_rsp_fifo (
    .clk_i,
    .rst_ni,
    .wvalid_i(rsp_wvalid),
    .wready_o(),
    .wdata_i (rsp_wdata),
    .rvalid_o(rsp_rvalid),
    .rready_i(rsp_pop),
    .rdata_o (rsp_rdata)
  );

  assign is_read   = (pend_i.req.op == sram_adapter_pkg::OpRead);
  // Only reads that went to the SRAM own an entry in the response FIFO
  assign good_read = is_read && !pend_i.req.error;

  // Writes and errors answer at once, good reads wait for their data
  assign d_valid_o = pend_i.req_valid && (!good_read || rsp_rvalid);
  assign d_ack     = d_valid_o && d_ready_i;

  assign pend_i.req_pop = d_ack;
  assign rsp_pop        = d_ack && good_read;

  assign d_opcode_o = is_read ? tlul_pkg::AccessAckData : tlul_pkg::AccessAck;
  assign d_size_o   = d_valid_o ? pend_i.req.size : '0;
  assign d_source_o = d_valid_o ? pend_i.req.source : '0;
  assign d_data_o   = (d_valid_o && good_read) ? rsp_rdata[tlul_pkg::TlDw-1:0] : '0;
  assign d_error_o  = d_valid_o &&
                      (pend_i.req.error || (good_read && rsp_rdata[tlul_pkg::TlDw]));

endmodule

// File: sram_adapter/tlul_sram_adapter.sv
// ============================================================
// TL-UL to SRAM adapter top level
// Wires the decode, issue and response stages
// ============================================================
`timescale 1ns/1ps

module tlul_sram_adapter #(
  parameter int SramAw      = 12,
  parameter int SramDw      = 32,
  parameter int Outstanding = 2,
  parameter bit ByteAccess  = 1'b1,
  parameter bit ErrOnWrite  = 1'b0,
  parameter bit ErrOnRead   = 1'b0
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // A channel
  input  logic                         a_valid_i,
  input  tlul_pkg::tl_a_op_e           a_opcode_i,
  input  logic [tlul_pkg::TlSzw-1:0]   a_size_i,
  input  logic [tlul_pkg::TlAiw-1:0]   a_source_i,
  input  logic [tlul_pkg::TlAw-1:0]    a_address_i,
  input  logic [tlul_pkg::TlDbw-1:0]   a_mask_i,
  input  logic [tlul_pkg::TlDw-1:0]    a_data_i,
  input  tlul_pkg::tl_type_e           a_type_i,
  output logic                         a_ready_o,
  // D channel
  output logic                         d_valid_o,
  output tlul_pkg::tl_d_op_e           d_opcode_o,
  output logic [tlul_pkg::TlSzw-1:0]   d_size_o,
  output logic [tlul_pkg::TlAiw-1:0]   d_source_o,
  output logic [tlul_pkg::TlDw-1:0]    d_data_o,
  output logic                         d_error_o,
  input  logic                         d_ready_i,
  input  tlul_pkg::tl_instr_en_e       en_ifetch_i,
  // SRAM
  output logic                         req_o,
  input  logic                         gnt_i,
  output logic                         we_o,
  output logic [SramAw-1:0]            addr_o,
  output logic [SramDw-1:0]            wdata_o,
  output logic [SramDw-1:0]            wmask_o,
  input  logic [SramDw-1:0]            rdata_i,
  input  logic                         rvalid_i,
  input  logic                         rerror_i
);

  req_dec_if #(.SramAw(SramAw)) dec_bus ();
  pend_if pend_bus ();

  tlul_req_decode #(
    .SramAw(SramAw), .SramDw(SramDw), .ByteAccess(ByteAccess),
    .ErrOnWrite(ErrOnWrite), .ErrOnRead(ErrOnRead)
  ) u_decode (
    .a_valid_i, .a_opcode_i, .a_size_i, .a_source_i, .a_address_i,
    .a_mask_i, .a_data_i, .a_type_i, .en_ifetch_i,
    .dec_if(dec_bus.dec)
  );

  sram_req_issue #(.SramAw(SramAw), .SramDw(SramDw), .Outstanding(Outstanding)) u_issue (
    .clk_i, .rst_ni,
    .iss_if(dec_bus.iss),
    .gnt_i, .a_ready_o, .req_o, .we_o, .addr_o, .wdata_o, .wmask_o,
    .pend_o(pend_bus.iss)
  );

  tlul_rsp_build #(.SramDw(SramDw), .Outstanding(Outstanding)) u_rsp (
    .clk_i, .rst_ni,
    .pend_i(pend_bus.rsp),
    .rdata_i, .rvalid_i, .rerror_i, .d_ready_i,
    .d_valid_o, .d_opcode_o, .d_size_o, .d_source_o, .d_data_o, .d_error_o
  );

endmodule

// File: testbench/tb_sram_model.sv
// ============================================================
// Behavioral SRAM with a random grant, masked writes and a
// one cycle read return that flags a poison word
// ============================================================
`timescale 1ns/1ps

module tb_sram_model #(
  parameter int Aw         = 12,
  parameter int Dw         = 64,
  parameter int PoisonAddr = 'hFF
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          req_i,
  output logic          gnt_o,
  input  logic          we_i,
  input  logic [Aw-1:0] addr_i,
  input  logic [Dw-1:0] wdata_i,
  input  logic [Dw-1:0] wmask_i,
  output logic [Dw-1:0] rdata_o,
  output logic          rvalid_o,
  output logic          rerror_o
);

  logic [Dw-1:0] mem [2**Aw];
  integer        seed = 19;

  // Every address bit goes into the fill value of each bus word
  initial begin
    for (int i = 0; i < 2**Aw; i++) begin
      for (int w = 0; w < Dw / 32; w++) begin
        mem[i][32*w +: 32] = (32'(i) * 32'h9E3779B1) ^ {8'(w), 24'hA5C35A};
      end
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rerror_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      // The grant toggles at random, with or without a request
      gnt_o    <= 1'($random(seed));
      rvalid_o <= req_i && gnt_o && !we_i;
      rerror_o <= req_i && gnt_o && !we_i && (addr_i == Aw'(PoisonAddr));
      if (req_i && gnt_o) begin
        if (we_i) begin
          mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
        end else begin
          rdata_o <= mem[addr_i];
        end
      end
    end
  end

endmodule

// File: testbench/tb_tlul_sram_adapter.sv
// ============================================================
// Testbench for the TL-UL SRAM adapter with directed tests, a
// response scoreboard, assertions and a watchdog
// ============================================================
`timescale 1ns/1ps

module tb_tlul_sram_adapter;

  localparam int SramAw     = 12;
  localparam int SramDw     = 64;
  localparam int ClkHalf    = 50;
  localparam int NumTests   = 5;
  localparam int PoisonWord = 'hFF;
  localparam tlul_pkg::tl_a_op_e OpGet     = tlul_pkg::Get;
  localparam tlul_pkg::tl_a_op_e OpPutFull = tlul_pkg::PutFullData;
  localparam tlul_pkg::tl_a_op_e OpPutPart = tlul_pkg::PutPartialData;

  // One expected D beat
  // Data is skipped for reads that end in an error
  typedef struct packed {
    tlul_pkg::tl_d_op_e opcode;
    logic [1:0]         size;
    logic [7:0]         source;
    logic [31:0]        data;
    logic               error;
    logic               chk_data;
  } exp_rsp_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   a_valid_i;
  logic                   a_ready_o;
  tlul_pkg::tl_a_op_e     a_opcode_i;
  logic [1:0]             a_size_i;
  logic [7:0]             a_source_i;
  logic [31:0]            a_address_i;
  logic [3:0]             a_mask_i;
  logic [31:0]            a_data_i;
  tlul_pkg::tl_type_e     a_type_i;
  tlul_pkg::tl_instr_en_e en_ifetch_i;
  logic                   d_valid_o;
  logic                   d_ready_i;
  tlul_pkg::tl_d_op_e     d_opcode_o;
  logic [1:0]             d_size_o;
  logic [7:0]             d_source_o;
  logic [31:0]            d_data_o;
  logic                   d_error_o;
  logic                   req_o;
  logic                   gnt_i;
  logic                   we_o;
  logic [SramAw-1:0]      addr_o;
  logic [SramDw-1:0]      wdata_o;
  logic [SramDw-1:0]      wmask_o;
  logic [SramDw-1:0]      rdata_i;
  logic                   rvalid_i;
  logic                   rerror_i;
  // High while the request on the A channel must be rejected by decode
  logic                   bad_req;

  exp_rsp_t    exp_q[$];
  logic [31:0] shadow [int unsigned];
  string       cur_test;
  int          errors;
  int          checks;
  int          test_errs;
  int          accepted;
  integer      seed = 19;

  tlul_sram_adapter #(
    .SramAw(SramAw), .SramDw(SramDw), .Outstanding(2)
  ) tlul_sram_adapter_inst (.*);

  tb_sram_model #(.Aw(SramAw), .Dw(SramDw), .PoisonAddr(PoisonWord)) sram_model_inst (
    .clk_i, .rst_ni, .req_i(req_o), .gnt_o(gnt_i), .we_i(we_o), .addr_i(addr_o),
    .wdata_i(wdata_o), .wmask_i(wmask_o), .rdata_o(rdata_i), .rvalid_o(rvalid_i),
    .rerror_o(rerror_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkHalf) clk_i = ~clk_i;
  end

  function automatic logic [31:0] expand_mask(input logic [3:0] mask);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        bits[8*i +: 8] = 8'hFF;
      end
    end
    return bits;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  // Drive one request, wait for its A transfer and queue the response it must get
  task automatic send_req(input tlul_pkg::tl_a_op_e op, input logic [1:0] size,
                          input logic [7:0] src, input logic [31:0] addr,
                          input logic [3:0] mask, input logic [31:0] data,
                          input bit instr, input bit rejected);
    exp_rsp_t    e;
    logic [31:0] bm;
    int unsigned key;
    bit          is_get;
    is_get = (op == OpGet);
    bm     = expand_mask(mask);
    key    = addr >> 2;
    @(posedge clk_i);
    a_valid_i   <= 1'b1;
    a_opcode_i  <= op;
    a_size_i    <= size;
    a_source_i  <= src;
    a_address_i <= addr;
    a_mask_i    <= mask;
    a_data_i    <= data;
    a_type_i    <= instr ? tlul_pkg::InstrType : tlul_pkg::DataType;
    bad_req     <= rejected;
    do begin
      @(posedge clk_i);
    end while (!a_ready_o);
    a_valid_i <= 1'b0;
    bad_req   <= 1'b0;
    accepted++;
    e.opcode = is_get ? tlul_pkg::AccessAckData : tlul_pkg::AccessAck;
    e.size   = size;
    e.source = src;
    // Byte address bits 14:3 pick the 64 bit SRAM word
    e.error    = rejected || (is_get && (addr[14:3] == 12'(PoisonWord)));
    e.chk_data = !(is_get && e.error);
    e.data     = '0;
    if (!rejected && is_get) begin
      e.data = shadow[key] & bm;
    end else if (!rejected) begin
      shadow[key] = (shadow[key] & ~bm) | (data & bm);
    end
    exp_q.push_back(e);
  endtask

  task automatic finish_test(input int num);
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    $display("Test %0d %s done with %0d errors", num, cur_test, test_errs);
  endtask

  // Each D transfer must match the oldest queued response
  always @(posedge clk_i) begin
    exp_rsp_t e;
    if (rst_ni && d_valid_o && d_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("D response from source %h arrived with nothing pending in test %s",
                 d_source_o, cur_test);
        errors++;
        test_errs++;
      end else begin
        e = exp_q.pop_front();
        check_value("d_opcode_o", e.opcode, d_opcode_o);
        check_value("d_size_o", e.size, d_size_o);
        check_value("d_source_o", e.source, d_source_o);
        check_value("d_error_o", e.error, d_error_o);
        if (e.chk_data) begin
          check_value("d_data_o", e.data, d_data_o);
        end
      end
    end
  end

  // A rejected request never reaches the SRAM
  no_sram_req_on_error: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (a_valid_i && bad_req) |-> !req_o)
  else begin
    $display("CHECK FAILED %s req_o: expected 0, actual 1", cur_test);
    errors++;
    test_errs++;
  end

  // A stalled D beat keeps its valid and fields
  d_hold_when_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (d_valid_o && !d_ready_i) |=> (d_valid_o && $stable(d_opcode_o) && $stable(d_size_o) &&
                                   $stable(d_source_o) && $stable(d_data_o) &&
                                   $stable(d_error_o)))
  else begin
    $display("D beat changed while d_ready_i was low in test %s", cur_test);
    errors++;
    test_errs++;
  end

  // Watchdog sized at 200 cycles per test
  initial begin
    repeat (NumTests * 200) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", NumTests * 200);
    $display("Errors found");
    $finish;
  end

  initial begin
    logic [31:0] rnd;
    int          base;
    rst_ni      = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = OpGet;
    a_size_i    = '0;
    a_source_i  = '0;
    a_address_i = '0;
    a_mask_i    = '0;
    a_data_i    = '0;
    a_type_i    = tlul_pkg::DataType;
    en_ifetch_i = tlul_pkg::InstrEn;
    d_ready_i   = 1'b1;
    bad_req     = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    cur_test  = "write_read";
    test_errs = 0;
    send_req(OpPutFull, 2'd2, 8'h11, 32'h100, 4'hF, 32'hDEADBEEF, 0, 0);
    send_req(OpGet, 2'd2, 8'h12, 32'h100, 4'hF, '0, 0, 0);
    send_req(OpGet, 2'd1, 8'h13, 32'h102, 4'hC, '0, 0, 0);
    finish_test(1);

    cur_test  = "partial_lanes";
    test_errs = 0;
    send_req(OpPutFull, 2'd2, 8'h21, 32'h200, 4'hF, 32'h11223344, 0, 0);
    send_req(OpPutFull, 2'd2, 8'h22, 32'h204, 4'hF, 32'h55667788, 0, 0);
    send_req(OpPutPart, 2'd2, 8'h23, 32'h200, 4'h5, 32'hAABBCCDD, 0, 0);
    send_req(OpPutPart, 2'd0, 8'h24, 32'h207, 4'h8, 32'hEE000000, 0, 0);
    send_req(OpPutPart, 2'd1, 8'h25, 32'h204, 4'h3, 32'h0000F00D, 0, 0);
    send_req(OpGet, 2'd2, 8'h26, 32'h200, 4'hF, '0, 0, 0);
    send_req(OpGet, 2'd2, 8'h27, 32'h204, 4'hF, '0, 0, 0);
    send_req(OpGet, 2'd1, 8'h28, 32'h206, 4'hC, '0, 0, 0);
    send_req(OpGet, 2'd0, 8'h29, 32'h201, 4'h2, '0, 0, 0);
    finish_test(2);

    cur_test  = "rejected_requests";
    test_errs = 0;
    send_req(OpPutFull, 2'd2, 8'h31, 32'h300, 4'hF, 32'hCAFEF00D, 0, 0);
    send_req(OpPutFull, 2'd2, 8'h32, 32'h302, 4'hF, 32'h0BADBEEF, 0, 1);
    send_req(OpGet, 2'd3, 8'h33, 32'h300, 4'hF, '0, 0, 1);
    send_req(OpGet, 2'd0, 8'h34, 32'h300, 4'h6, '0, 0, 1);
    send_req(OpPutFull, 2'd2, 8'h35, 32'h300, 4'h7, 32'h12345678, 0, 1);
    en_ifetch_i <= tlul_pkg::InstrDis;
    send_req(OpGet, 2'd2, 8'h36, 32'h300, 4'hF, '0, 1, 1);
    en_ifetch_i <= tlul_pkg::InstrEn;
    send_req(OpGet, 2'd2, 8'h37, 32'h300, 4'hF, '0, 1, 0);
    send_req(OpGet, 2'd2, 8'h38, 32'h300, 4'hF, '0, 0, 0);
    finish_test(3);

    cur_test  = "poison_read";
    test_errs = 0;
    send_req(OpPutFull, 2'd2, 8'h41, 32'h7F8, 4'hF, 32'h600DF00D, 0, 0);
    send_req(OpGet, 2'd2, 8'h42, 32'h7F8, 4'hF, '0, 0, 0);
    send_req(OpGet, 2'd2, 8'h43, 32'h100, 4'hF, '0, 0, 0);
    finish_test(4);

    cur_test  = "backpressure";
    test_errs = 0;
    base      = accepted;
    d_ready_i <= 1'b0;
    fork
      begin
        // A leading read leaves its data waiting in the response FIFO
        send_req(OpGet, 2'd2, 8'h5F, 32'h100, 4'hF, '0, 0, 0);
        for (int i = 0; i < 3; i++) begin
          rnd = $random(seed);
          send_req(OpPutFull, 2'd2, 8'h50 + 8'(i), 32'h400 + 32'(4*i), 4'hF, rnd, 0, 0);
        end
        for (int i = 0; i < 3; i++) begin
          send_req(OpGet, 2'd2, 8'h60 + 8'(i), 32'h400 + 32'(4*i), 4'hF, '0, 0, 0);
        end
      end
      begin
        // Two pending requests fill the FIFOs and stall the A channel
        while (accepted < base + 2) begin
          @(posedge clk_i);
        end
        repeat (4) begin
          @(posedge clk_i);
          check_value("a_ready_o", 32'd0, a_ready_o);
        end
        d_ready_i <= 1'b1;
      end
    join
    finish_test(5);

    $display("Tests run: %0d, checks: %0d, errors: %0d", NumTests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: compile.f
common/tlul_pkg.sv
common/sram_adapter_pkg.sv
common/adapter_ifs.sv
logic/sync_fifo.sv
sram_adapter/tlul_req_decode.sv
sram_adapter/sram_req_issue.sv
sram_adapter/tlul_rsp_build.sv
sram_adapter/tlul_sram_adapter.sv
testbench/tb_sram_model.sv
testbench/tb_tlul_sram_adapter.sv

// File: Bender.yml
package:
  name: tlul_sram_adapter

sources:
  # Packages first, then interfaces and the RTL in dependency order
  - files:
      - common/tlul_pkg.sv
      - common/sram_adapter_pkg.sv
      - common/adapter_ifs.sv
      - logic/sync_fifo.sv
      - sram_adapter/tlul_req_decode.sv
      - sram_adapter/sram_req_issue.sv
      - sram_adapter/tlul_rsp_build.sv
      - sram_adapter/tlul_sram_adapter.sv

  # Simulation only sources
  - target: test
    files:
      - testbench/tb_sram_model.sv
      - testbench/tb_tlul_sram_adapter.sv
